// ==== bench/chkpt_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chkpt_defines.svh"

module chkpt_unit_tb;

	import chkpt_pkg::*;

	// Index shown by a slot without a branch, as a plain integer for the table
	localparam int NO_CP = int'(CHK_NONE);

	// One table row, applied for exactly one clock cycle
	typedef struct packed {
		logic gv;
		logic [`CHK_GROUP-1:0] br;
		logic fva;
		chkpt_ndx_t fna;
		logic fvb;
		chkpt_ndx_t fnb;
		chkpt_map_t flush;
		logic use_model;
		logic rdy;
		chkpt_ndx_t e0;
		chkpt_ndx_t e1;
		chkpt_ndx_t e2;
		chkpt_ndx_t e3;
	} step_t;

	logic clk5x;
	logic rst;
	logic group_valid;
	logic [`CHK_GROUP-1:0] group_branches;
	logic group_ready;
	chkpt_ndx_t chkpt_0;
	chkpt_ndx_t chkpt_1;
	chkpt_ndx_t chkpt_2;
	chkpt_ndx_t chkpt_3;
	logic free_valid_a;
	chkpt_ndx_t free_ndx_a;
	logic free_valid_b;
	chkpt_ndx_t free_ndx_b;
	chkpt_map_t flush_mask;

	step_t steps[$];
	int seed;
	int errors;
	int checks;

	// Reference model of the free bitmap and of the release mask still in flight
	chkpt_map_t model_map;
	chkpt_map_t model_rel;
	chkpt_map_t model_left;
	logic model_rdy;
	chkpt_ndx_t model_ndx [0:`CHK_GROUP-1];

	chkpt_unit chkpt_unit_i (
		.clk5x(clk5x),
		.rst(rst),
		.group_valid(group_valid),
		.group_branches(group_branches),
		.group_ready(group_ready),
		.chkpt_0(chkpt_0),
		.chkpt_1(chkpt_1),
		.chkpt_2(chkpt_2),
		.chkpt_3(chkpt_3),
		.free_valid_a(free_valid_a),
		.free_ndx_a(free_ndx_a),
		.free_valid_b(free_valid_b),
		.free_ndx_b(free_ndx_b),
		.flush_mask(flush_mask)
	);

	always #10 clk5x = ~clk5x;

	// ==============================
	// Stimulus table
	// ==============================

	task automatic add_step(input int gv, input int br, input int fva, input int fna,
		input int fvb, input int fnb, input int fl, input int rdy,
		input int e0, input int e1, input int e2, input int e3);
		step_t st;
		st.gv = gv[0];
		st.br = br[`CHK_GROUP-1:0];
		st.fva = fva[0];
		st.fna = chkpt_ndx_t'(fna);
		st.fvb = fvb[0];
		st.fnb = chkpt_ndx_t'(fnb);
		st.flush = chkpt_map_t'(fl);
		st.use_model = 1'b0;
		st.rdy = rdy[0];
		st.e0 = chkpt_ndx_t'(e0);
		st.e1 = chkpt_ndx_t'(e1);
		st.e2 = chkpt_ndx_t'(e2);
		st.e3 = chkpt_ndx_t'(e3);
		steps.push_back(st);
	endtask

	// A random flush followed by two random groups, all predicted by the model
	task automatic add_random_round();
		step_t st;
		int r;
		st = '0;
		st.use_model = 1'b1;
		// Two words ANDed so that only about a quarter of the pool comes back
		st.flush = chkpt_map_t'($random(seed) & $random(seed));
		steps.push_back(st);
		st.flush = '0;
		st.gv = 1'b1;
		for (int n = 0; n < 2; n++) begin
			r = $random(seed);
			st.br = r[`CHK_GROUP-1:0];
			steps.push_back(st);
		end
	endtask

	task automatic build_table();
		// Slots 0 and 2 right after reset
		add_step(1, 'b0101, 0, 0, 0, 0, 'h0000, 1, 1, NO_CP, 2, NO_CP);
		// Fill the pool up to index 14
		add_step(1, 'b1111, 0, 0, 0, 0, 'h0000, 1, 3, 4, 5, 6);
		add_step(1, 'b1111, 0, 0, 0, 0, 'h0000, 1, 7, 8, 9, 10);
		add_step(1, 'b1111, 0, 0, 0, 0, 'h0000, 1, 11, 12, 13, 14);
		// Only 15 is left, so four branches are held back and one goes through
		add_step(1, 'b1111, 0, 0, 0, 0, 'h0000, 0, 15, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0001, 0, 0, 0, 0, 'h0000, 1, 15, NO_CP, NO_CP, NO_CP);
		// Free 5 and 9 together while a two-branch group waits
		add_step(1, 'b0011, 1, 5, 1, 9, 'h0000, 0, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0011, 0, 0, 0, 0, 'h0000, 0, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0011, 0, 0, 0, 0, 'h0000, 1, 5, 9, NO_CP, NO_CP);
		// Flush of 0 to 4 where bit 0 must be dropped
		add_step(0, 'b0000, 0, 0, 0, 0, 'h001f, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(0, 'b0000, 0, 0, 0, 0, 'h0000, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b1111, 0, 0, 0, 0, 'h0000, 1, 1, 2, 3, 4);
		add_step(1, 'b0001, 0, 0, 0, 0, 'h0000, 0, NO_CP, NO_CP, NO_CP, NO_CP);
		// Empty groups go through at any time and take nothing
		add_step(0, 'b0000, 1, 7, 1, 12, 'h0100, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0000, 0, 0, 0, 0, 'h0000, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0000, 0, 0, 0, 0, 'h0000, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0110, 0, 0, 0, 0, 'h0000, 1, NO_CP, 7, 8, NO_CP);
		// Release of 3 lands on the same edge as the allocation of 12.
		// Port b tries to free checkpoint 0, which must have no effect
		add_step(0, 'b0000, 1, 3, 1, 0, 'h0000, 1, NO_CP, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b0001, 0, 0, 0, 0, 'h0000, 1, 12, NO_CP, NO_CP, NO_CP);
		add_step(1, 'b1000, 0, 0, 0, 0, 'h0000, 1, NO_CP, NO_CP, NO_CP, 3);
		add_step(1, 'b0001, 0, 0, 0, 0, 'h0000, 0, NO_CP, NO_CP, NO_CP, NO_CP);
		for (int n = 0; n < 10; n++) begin
			add_random_round();
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Lowest free index per marked slot in slot order, checkpoint 0 excluded
	task automatic model_outputs(input logic [`CHK_GROUP-1:0] br);
		chkpt_map_t avail;
		int k;
		avail = model_map;
		model_rdy = 1'b1;
		for (int s = 0; s < `CHK_GROUP; s++) begin
			model_ndx[s] = CHK_NONE;
			if (br[s]) begin
				k = 1;
				while (k < `CHK_NCHECK && !avail[k]) begin
					k++;
				end
				if (k < `CHK_NCHECK) begin
					model_ndx[s] = chkpt_ndx_t'(k);
					avail[k] = 1'b0;
				end else begin
					model_rdy = 1'b0;
				end
			end
		end
		model_left = avail;
	endtask

	// Advances the model by one rising edge
	// Frees seen now reach the bitmap one edge after the group update
	task automatic model_clock(input step_t st);
		chkpt_map_t freed;
		freed = st.flush;
		if (st.fva) begin
			freed = freed | (chkpt_map_t'(1) << st.fna);
		end
		if (st.fvb) begin
			freed = freed | (chkpt_map_t'(1) << st.fnb);
		end
		freed[0] = 1'b0;
		if (st.gv && model_rdy) begin
			model_map = model_left | model_rel;
		end else begin
			model_map = model_map | model_rel;
		end
		model_rel = freed;
	endtask

	// ==============================
	// Drive, wait and compare
	// ==============================

	task automatic apply_step(input step_t st);
		group_valid = st.gv;
		group_branches = st.br;
		free_valid_a = st.fva;
		free_ndx_a = st.fna;
		free_valid_b = st.fvb;
		free_ndx_b = st.fnb;
		flush_mask = st.flush;
	endtask

	// Polled on falling edges, where group_ready has long settled
	task automatic wait_ready(input int limit, output logic timed_out);
		int n;
		n = 0;
		while (group_ready !== 1'b1 && n < limit) begin
			@(negedge clk5x);
			n++;
		end
		timed_out = group_ready !== 1'b1;
		if (timed_out) begin
			$display("Timeout: group_ready stayed low for %0d cycles after reset", limit);
		end
	endtask

	task automatic check_ndx(input string name, input chkpt_ndx_t got,
		input chkpt_ndx_t exp, input int step);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error step %0d: %s = 0x%h, expected 0x%h", step, name, got, exp);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input int step);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error step %0d: group_ready = 0x%h, expected 0x%h", step, got, exp);
		end
	endtask

	initial begin
		step_t st;
		chkpt_ndx_t e [0:`CHK_GROUP-1];
		logic exp_rdy;
		logic timed_out;
		clk5x = 1'b0;
		rst = 1'b1;
		apply_step('0);
		// A full four-branch group has to be coverable straight out of reset
		group_branches = '1;
		seed = 32'hf96e_ad17;
		errors = 0;
		checks = 0;
		model_map = ~chkpt_map_t'(1);
		model_rel = '0;
		build_table();
		repeat (8) @(posedge clk5x);
		@(negedge clk5x);
		rst = 1'b0;
		wait_ready(4, timed_out);
		if (timed_out) begin
			errors++;
		end else begin
			foreach (steps[n]) begin
				st = steps[n];
				apply_step(st);
				// Outputs are combinational, so half a cycle is ample to settle
				#5;
				model_outputs(st.br);
				if (st.use_model) begin
					exp_rdy = model_rdy;
					e = model_ndx;
				end else begin
					exp_rdy = st.rdy;
					e[0] = st.e0;
					e[1] = st.e1;
					e[2] = st.e2;
					e[3] = st.e3;
				end
				check_ready(group_ready, exp_rdy, n);
				check_ndx("chkpt_0", chkpt_0, e[0], n);
				check_ndx("chkpt_1", chkpt_1, e[1], n);
				check_ndx("chkpt_2", chkpt_2, e[2], n);
				check_ndx("chkpt_3", chkpt_3, e[3], n);
				@(posedge clk5x);
				model_clock(st);
				@(negedge clk5x);
			end
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/chkpt_pkg.sv
source/find_first_one.sv
source/chkpt_release.sv
source/chkpt_allocator.sv
source/chkpt_unit.sv
bench/chkpt_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the checkpoint unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module chkpt_unit_tb -o chkpt_unit_sim

./obj_dir/chkpt_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi

echo "Simulation finished without errors"
exit 0

// ==== source/chkpt_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chkpt_defines.svh"

// Branch checkpoint allocator for one decoded instruction group
// Every marked branch slot gets its own checkpoint in the same cycle,
// lowest free index first and in slot order
module chkpt_allocator (
	input logic clk5x,
	input logic rst,
	input logic group_valid,
	input logic [`CHK_GROUP-1:0] group_branches,
	output logic group_ready,
	output chkpt_pkg::chkpt_ndx_t chkpt_0,
	output chkpt_pkg::chkpt_ndx_t chkpt_1,
	output chkpt_pkg::chkpt_ndx_t chkpt_2,
	output chkpt_pkg::chkpt_ndx_t chkpt_3,
	input chkpt_pkg::chkpt_map_t release_mask
);

	import chkpt_pkg::*;

	// Everything free except the reserved checkpoint 0
	localparam chkpt_map_t MAP_RESET = ~chkpt_map_t'(1);

	// Bitmap of checkpoints that can be handed out
	chkpt_map_t free_map;

	// Map seen by each encoder stage, plus the map left after the last one
	chkpt_map_t stage_map [0:`CHK_GROUP];

	// Bit taken out of the map by each stage, zero for an unmarked slot
	chkpt_map_t take_mask [0:`CHK_GROUP-1];

	// Raw encoder result for each stage
	chkpt_ndx_t found [0:`CHK_GROUP-1];

	// Index shown on each slot output
	chkpt_ndx_t slot_ndx [0:`CHK_GROUP-1];

	// A marked slot whose encoder came up empty
	logic [`CHK_GROUP-1:0] slot_short;

	logic transfer;

	// ==============================
	// Encoder chain
	// ==============================

	assign stage_map[0] = free_map;

	// Each stage looks at what the earlier slots left behind.
	// Only a marked slot removes its bit, so an unmarked slot passes the map
	// on untouched and the next branch still sees the same lowest index
	for (genvar g = 0; g < `CHK_GROUP; g++) begin : g_slot
		find_first_one u_ffo (
			.i(stage_map[g]),
			.o(found[g])
		);

		// Shifting by CHK_NONE would walk off the map, so guard on it
		assign take_mask[g] = (group_branches[g] && found[g] != CHK_NONE)
			? (chkpt_map_t'(1) << found[g]) : '0;

		assign stage_map[g+1] = stage_map[g] & ~take_mask[g];

		// Once one stage runs dry every later stage does as well
		assign slot_short[g] = group_branches[g] && found[g] == CHK_NONE;

		// Slots without a branch report no checkpoint
		assign slot_ndx[g] = group_branches[g] ? found[g] : CHK_NONE;
	end

	assign chkpt_0 = slot_ndx[0];
	assign chkpt_1 = slot_ndx[1];
	assign chkpt_2 = slot_ndx[2];
	assign chkpt_3 = slot_ndx[3];

	// ==============================
	// Handshake
	// ==============================

	// The group is only taken when every branch in it can be covered.
	// A group with no branches never runs short, so it is always ready
	assign group_ready = ~|slot_short;

	assign transfer = group_valid && group_ready;

	// ==============================
	// Free bitmap
	// ==============================

	// On a transfer the reduced map from the end of the chain is kept.
	// Released checkpoints are merged on every edge, so a release and an
	// allocation landing on the same edge both take effect.
	// While the group is held back only releases change the map
	always_ff @(posedge clk5x) begin
		if (rst) begin
			free_map <= MAP_RESET;
		end else if (transfer) begin
			free_map <= stage_map[`CHK_GROUP] | release_mask;
		end else begin
			free_map <= free_map | release_mask;
		end
	end

endmodule

`default_nettype wire

// ==== source/chkpt_defines.svh ====
`ifndef CHKPT_DEFINES_SVH
`define CHKPT_DEFINES_SVH

// Number of branch checkpoints in the pool
// A pool of 32 works as well
`define CHK_NCHECK 16

// Instruction slots in one decoded group
`define CHK_GROUP 4

// One extra bit above the index range so that all ones can mean no checkpoint
`define CHK_NDX_W ($clog2(`CHK_NCHECK) + 1)

`endif

// ==== source/chkpt_pkg.sv ====
`default_nettype none

`include "chkpt_defines.svh"

package chkpt_pkg;

	// ==============================
	// Checkpoint types
	// ==============================

	// Index of one checkpoint, wide enough to also hold the none code
	typedef logic [`CHK_NDX_W-1:0] chkpt_ndx_t;

	// One bit per checkpoint
	// A set bit marks a checkpoint that is free, or that is about to be freed
	typedef logic [`CHK_NCHECK-1:0] chkpt_map_t;

	// All ones never names a real checkpoint since its top bit is set
	localparam chkpt_ndx_t CHK_NONE = '1;

endpackage

`default_nettype wire

// ==== source/chkpt_release.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chkpt_defines.svh"

// Gathers every checkpoint coming back in one cycle into a single mask
// Sources are the two resolved-branch ports and the misprediction flush mask
module chkpt_release (
	input logic clk5x,
	input logic rst,
	input logic free_valid_a,
	input chkpt_pkg::chkpt_ndx_t free_ndx_a,
	input logic free_valid_b,
	input chkpt_pkg::chkpt_ndx_t free_ndx_b,
	input chkpt_pkg::chkpt_map_t flush_mask,
	output chkpt_pkg::chkpt_map_t release_mask
);

	import chkpt_pkg::*;

	// ==============================
	// Index decode
	// ==============================

	// Turns one freed index into a one-hot map
	// An invalid port, or an index outside the pool, gives an empty map
	function automatic chkpt_map_t decode_free(input logic valid, input chkpt_ndx_t ndx);
		chkpt_map_t hot;
		hot = '0;
		for (int n = 0; n < `CHK_NCHECK; n++) begin
			if (valid && ndx == chkpt_ndx_t'(n)) begin
				hot[n] = 1'b1;
			end
		end
		return hot;
	endfunction

	chkpt_map_t free_bits;

	// Both ports naming the same index simply set the same bit twice
	always_comb begin
		free_bits = flush_mask | decode_free(free_valid_a, free_ndx_a)
			| decode_free(free_valid_b, free_ndx_b);
		// Checkpoint 0 is reserved and must never come back into the pool
		free_bits[0] = 1'b0;
	end

	// ==============================
	// Release register
	// ==============================

	// One cycle of delay before the allocator sees the freed bits
	always_ff @(posedge clk5x) begin
		if (rst) begin
			release_mask <= '0;
		end else begin
			release_mask <= free_bits;
		end
	end

endmodule

`default_nettype wire

// ==== source/chkpt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chkpt_defines.svh"

// Checkpoint unit of the rename stage
// Freed checkpoints pass through the release register before the allocator
// merges them, so a freed index is usable two edges after it arrives
module chkpt_unit (
	input logic clk5x,
	input logic rst,
	input logic group_valid,
	input logic [`CHK_GROUP-1:0] group_branches,
	output logic group_ready,
	output chkpt_pkg::chkpt_ndx_t chkpt_0,
	output chkpt_pkg::chkpt_ndx_t chkpt_1,
	output chkpt_pkg::chkpt_ndx_t chkpt_2,
	output chkpt_pkg::chkpt_ndx_t chkpt_3,
	input logic free_valid_a,
	input chkpt_pkg::chkpt_ndx_t free_ndx_a,
	input logic free_valid_b,
	input chkpt_pkg::chkpt_ndx_t free_ndx_b,
	input chkpt_pkg::chkpt_map_t flush_mask
);

	import chkpt_pkg::*;

	// Registered set of checkpoints returning to the pool
	chkpt_map_t release_mask;

	chkpt_release chkpt_release_i (
		.clk5x(clk5x),
		.rst(rst),
		.free_valid_a(free_valid_a),
		.free_ndx_a(free_ndx_a),
		.free_valid_b(free_valid_b),
		.free_ndx_b(free_ndx_b),
		.flush_mask(flush_mask),
		.release_mask(release_mask)
	);

	chkpt_allocator chkpt_allocator_i (
		.clk5x(clk5x),
		.rst(rst),
		.group_valid(group_valid),
		.group_branches(group_branches),
		.group_ready(group_ready),
		.chkpt_0(chkpt_0),
		.chkpt_1(chkpt_1),
		.chkpt_2(chkpt_2),
		.chkpt_3(chkpt_3),
		.release_mask(release_mask)
	);

endmodule

`default_nettype wire

// ==== source/find_first_one.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chkpt_defines.svh"

// Priority encoder over a checkpoint bitmap
// The lowest set bit wins, which keeps low indexes in use and the high ones idle
module find_first_one (
	input chkpt_pkg::chkpt_map_t i,
	output chkpt_pkg::chkpt_ndx_t o
);

	import chkpt_pkg::*;

	// Walk upward from bit 0 and latch the first hit
	// The output still holding CHK_NONE doubles as the "nothing found yet" flag,
	// which is safe because no real index has the top bit set
	always_comb begin
		o = CHK_NONE;
		for (int n = 0; n < `CHK_NCHECK; n++) begin
			if (i[n] && o == CHK_NONE) begin
				o = chkpt_ndx_t'(n);
			end
		end
	end

endmodule

`default_nettype wire
